// File: backup_ram_ctrl.sv
/* save ram backup controller */

`timescale 1ns/1ns

module backup_ram_ctrl
	import nes_glue_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset_nes,
	input  logic                         img_mounted,
	input  logic [31:0]                  img_size,
	input  logic                         downloading,
	input  logic                         bk_save,
	input  logic                         sd_ack,
	input  logic [sd_buff_addr_bits-1:0] sd_buff_addr,
	input  logic                         sd_buff_wr,
	input  logic                         sd_buff_rd,
	output logic [31:0]                  sd_lba,
	output logic                         sd_rd,
	output logic                         sd_wr,
	output logic [mem_addr_bits-1:0]     sram_addr,
	output logic                         sram_req,
	output logic                         sram_we,
	output logic                         save_enabled
);

	bk_state_t                    state;
	logic                         img_mounted_d;
	logic                         downloading_d;
	logic                         bk_load;
	logic                         bk_load_d;
	logic                         bk_save_d;
	logic                         sd_ack_d;
	logic                         bk_loading;
	logic [sav_size_bits-1:0]     sav_size;
	logic [sd_buff_addr_bits-1:0] sram_a;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state         <= bk_idle;
			sd_lba        <= '0;
			sd_rd         <= 1'b0;
			sd_wr         <= 1'b0;
			save_enabled  <= 1'b0;
			bk_load       <= 1'b0;
			img_mounted_d <= 1'b0;
			downloading_d <= 1'b0;
			bk_load_d     <= 1'b0;
			bk_save_d     <= 1'b0;
			sd_ack_d      <= 1'b0;
		end else begin
			img_mounted_d <= img_mounted;
			downloading_d <= downloading;
			bk_load_d     <= bk_load;
			bk_save_d     <= bk_save;
			sd_ack_d      <= sd_ack;
			bk_load       <= 1'b0;

			// mount of a save image, empty image disables backup
			if (!img_mounted_d && img_mounted) begin
				if (img_size != '0) begin
					save_enabled <= 1'b1;
					sav_size     <= img_size[20:9];
					bk_load      <= 1'b1;
				end else begin
					save_enabled <= 1'b0;
				end
			end
			if (!downloading_d && downloading) begin
				save_enabled <= 1'b0;
			end

			// host took the request
			if (!sd_ack_d && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				bk_idle: begin
					if (save_enabled && ((!bk_load_d && bk_load) || (!bk_save_d && bk_save))) begin
						state      <= bk_transfer;
						sd_lba     <= '0;
						bk_loading <= bk_load;
						sd_rd      <= bk_load;
						sd_wr      <= ~bk_load;
					end
				end
				bk_transfer: begin
					// block done on falling ack
					if (sd_ack_d && !sd_ack) begin
						if (sd_lba[sav_size_bits-1:0] == sav_size) begin
							state <= bk_idle;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= bk_idle;
			endcase
		end
	end

	// buffer side, one toggle per byte
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			sram_req <= 1'b0;
			sram_we  <= 1'b0;
		end else if (sd_buff_wr || sd_buff_rd) begin
			sram_req <= ~sram_req;
			sram_we  <= sd_buff_wr;
		end
	end

	always_ff @(posedge clk) begin
		if (sd_buff_wr || sd_buff_rd) begin
			sram_a <= sd_buff_addr;
		end
	end

	assign sram_addr = {sram_block_base, sd_lba[sd_buff_addr_bits-1:0], sram_a};

	// a request stands only inside a transfer, and never both ways
	a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset_nes)
		(sd_rd || sd_wr) |-> (state == bk_transfer && !(sd_rd && sd_wr)));

endmodule

// File: joypad_serial.sv
/* joypad serial registers */

`timescale 1ns/1ns

module joypad_serial
	import nes_glue_pkg::*;
(
	input  logic                    clk,
	input  logic                    machine_reset,
	input  logic [nes_joy_bits-1:0] nes_joy_a,
	input  logic [nes_joy_bits-1:0] nes_joy_b,
	input  logic                    joypad_strobe,
	input  logic [1:0]              joypad_clock,
	output logic                    joypad1_data,
	output logic                    joypad2_data
);

	logic [1:0][nes_joy_bits-1:0] shift_q;
	logic [1:0][nes_joy_bits-1:0] load_val;
	logic [1:0]                   joy_clk_q;

	assign load_val = {nes_joy_b, nes_joy_a};

	always_ff @(posedge clk) begin
		if (machine_reset) begin
			shift_q   <= '0;
			joy_clk_q <= '0;
		end else begin
			joy_clk_q <= joypad_clock;
			for (int i = 0; i < 2; i++) begin
				// strobe beats a falling clock on the same edge
				if (joypad_strobe) begin
					shift_q[i] <= load_val[i];
				end else if (joy_clk_q[i] && !joypad_clock[i]) begin
					shift_q[i] <= {1'b0, shift_q[i][nes_joy_bits-1:1]};
				end
			end
		end
	end

	assign joypad1_data = shift_q[0][0];
	assign joypad2_data = shift_q[1][0];

endmodule

// File: loader_write_sync.sv
/* loader write sync and port b mux */

`timescale 1ns/1ns

module loader_write_sync
	import nes_glue_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset_nes,
	input  logic                     downloading,
	input  logic                     loader_busy,
	input  logic                     loader_write,
	input  logic [mem_addr_bits-1:0] loader_addr,
	input  logic [7:0]               loader_data,
	input  logic [1:0]               mem_phase,
	input  logic [mem_addr_bits-1:0] cpu_addr,
	input  logic                     cpu_read,
	input  logic                     cpu_write,
	input  logic [7:0]               cpu_dout,
	output logic [mem_addr_bits-1:0] mem_addr_b,
	output logic                     mem_we_b,
	output logic                     mem_oe_b,
	output logic [7:0]               mem_din_b
);

	logic [mem_addr_bits-1:0] addr_q;
	logic [7:0]               data_q;
	logic                     pending_q;
	logic                     we_q;
	logic                     loading;

	always_ff @(posedge clk) begin
		if (loader_write) begin
			addr_q <= loader_addr;
			data_q <= loader_data;
		end
	end

	// write goes out for one full phase period
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			pending_q <= 1'b0;
			we_q      <= 1'b0;
		end else if (mem_phase == mem_phase_ppu) begin
			we_q      <= pending_q | loader_write;
			pending_q <= 1'b0;
		end else if (loader_write) begin
			pending_q <= 1'b1;
		end
	end

	assign loading = downloading | loader_busy;

	assign mem_addr_b = loading ? addr_q : cpu_addr;
	assign mem_din_b  = loading ? data_q : cpu_dout;
	assign mem_oe_b   = ~loading & cpu_read;
	assign mem_we_b   = we_q | cpu_write;

	// a loader write never lands on the cpu side of port b
	a_no_cpu_read_loading: assert property (@(posedge clk) disable iff (reset_nes)
		we_q |-> loading);

endmodule

// File: nes_glue_pkg.sv
/* nes host glue shared definitions */

package nes_glue_pkg;

	// host gamepad word, bits 0..9 in use
	localparam int host_joy_bits = 16;

	// nes pad shift register
	localparam int nes_joy_bits = 8;

	localparam int mem_addr_bits = 22;

	// byte address within one sd block
	localparam int sd_buff_addr_bits = 9;

	// save size in 512 byte blocks, minus one
	localparam int sav_size_bits = 12;

	// top address field of save ram in the memory map
	localparam logic [3:0] sram_block_base = 4'd15;

	// core phase at which loader writes go out
	localparam logic [1:0] mem_phase_ppu = 2'd3;

	typedef enum logic {
		bk_idle,
		bk_transfer
	} bk_state_t;

endpackage

// File: nes_host_glue.sv
/* nes host glue top */

`timescale 1ns/1ns

module nes_host_glue
	import nes_glue_pkg::*;
#(
	parameter int turbo_bits    = 20,
	parameter int download_hold = 255
) (
	input  logic                         clk,
	input  logic                         reset_nes,
	input  logic [host_joy_bits-1:0]     host_joy_a,
	input  logic [host_joy_bits-1:0]     host_joy_b,
	input  logic                         joy_swap,
	input  logic                         joypad_strobe,
	input  logic [1:0]                   joypad_clock,
	input  logic                         reset_button,
	input  logic                         arm_reset,
	input  logic                         downloading,
	input  logic                         loader_busy,
	input  logic                         loader_fail,
	input  logic                         loader_write,
	input  logic [mem_addr_bits-1:0]     loader_addr,
	input  logic [7:0]                   loader_data,
	input  logic [1:0]                   mem_phase,
	input  logic [mem_addr_bits-1:0]     cpu_addr,
	input  logic                         cpu_read,
	input  logic                         cpu_write,
	input  logic [7:0]                   cpu_dout,
	input  logic                         img_mounted,
	input  logic [31:0]                  img_size,
	input  logic                         bk_save,
	input  logic                         sd_ack,
	input  logic [sd_buff_addr_bits-1:0] sd_buff_addr,
	input  logic                         sd_buff_wr,
	input  logic                         sd_buff_rd,
	output logic                         joypad1_data,
	output logic                         joypad2_data,
	output logic                         machine_reset,
	output logic [mem_addr_bits-1:0]     mem_addr_b,
	output logic                         mem_we_b,
	output logic                         mem_oe_b,
	output logic [7:0]                   mem_din_b,
	output logic [31:0]                  sd_lba,
	output logic                         sd_rd,
	output logic                         sd_wr,
	output logic [mem_addr_bits-1:0]     sram_addr,
	output logic                         sram_req,
	output logic                         sram_we,
	output logic                         save_enabled
);

	logic [nes_joy_bits-1:0] nes_joy_a;
	logic [nes_joy_bits-1:0] nes_joy_b;

	pad_mapper #(
		.turbo_bits(turbo_bits)
	) i_pad_mapper (
		.clk       (clk),
		.reset_nes (reset_nes),
		.host_joy_a(host_joy_a),
		.host_joy_b(host_joy_b),
		.joy_swap  (joy_swap),
		.nes_joy_a (nes_joy_a),
		.nes_joy_b (nes_joy_b)
	);

	// pads are cleared along with the console
	joypad_serial i_joypad_serial (
		.clk          (clk),
		.machine_reset(machine_reset),
		.nes_joy_a    (nes_joy_a),
		.nes_joy_b    (nes_joy_b),
		.joypad_strobe(joypad_strobe),
		.joypad_clock (joypad_clock),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data)
	);

	reset_sequencer #(
		.download_hold(download_hold)
	) i_reset_sequencer (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.reset_button (reset_button),
		.arm_reset    (arm_reset),
		.downloading  (downloading),
		.loader_busy  (loader_busy),
		.loader_fail  (loader_fail),
		.machine_reset(machine_reset)
	);

	loader_write_sync i_loader_write_sync (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.downloading (downloading),
		.loader_busy (loader_busy),
		.loader_write(loader_write),
		.loader_addr (loader_addr),
		.loader_data (loader_data),
		.mem_phase   (mem_phase),
		.cpu_addr    (cpu_addr),
		.cpu_read    (cpu_read),
		.cpu_write   (cpu_write),
		.cpu_dout    (cpu_dout),
		.mem_addr_b  (mem_addr_b),
		.mem_we_b    (mem_we_b),
		.mem_oe_b    (mem_oe_b),
		.mem_din_b   (mem_din_b)
	);

	backup_ram_ctrl i_backup_ram_ctrl (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.downloading (downloading),
		.bk_save     (bk_save),
		.sd_ack      (sd_ack),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_wr  (sd_buff_wr),
		.sd_buff_rd  (sd_buff_rd),
		.sd_lba      (sd_lba),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.sram_addr   (sram_addr),
		.sram_req    (sram_req),
		.sram_we     (sram_we),
		.save_enabled(save_enabled)
	);

endmodule

// File: pad_mapper.sv
/* host to nes pad mapping */

`timescale 1ns/1ns

module pad_mapper
	import nes_glue_pkg::*;
#(
	parameter int turbo_bits = 20
) (
	input  logic                     clk,
	input  logic                     reset_nes,
	input  logic [host_joy_bits-1:0] host_joy_a,
	input  logic [host_joy_bits-1:0] host_joy_b,
	input  logic                     joy_swap,
	output logic [nes_joy_bits-1:0]  nes_joy_a,
	output logic [nes_joy_bits-1:0]  nes_joy_b
);

	logic [turbo_bits-1:0]    turbo_cnt;
	logic                     turbo;
	logic [host_joy_bits-1:0] joy_a;
	logic [host_joy_bits-1:0] joy_b;

	// serial order: A B select start up down left right
	// X and Y act as turbo A and B
	function automatic logic [nes_joy_bits-1:0] map_pad(
		input logic [host_joy_bits-1:0] joy,
		input logic                     gate
	);
		return {joy[0], joy[1], joy[2], joy[3], joy[7], joy[6],
			joy[5] | (joy[9] & gate), joy[4] | (joy[8] & gate)};
	endfunction

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			turbo_cnt <= '0;
		end else begin
			turbo_cnt <= turbo_cnt + 1'b1;
		end
	end

	assign turbo = turbo_cnt[turbo_bits-1];

	assign joy_a = joy_swap ? host_joy_b : host_joy_a;
	assign joy_b = joy_swap ? host_joy_a : host_joy_b;

	assign nes_joy_a = map_pad(joy_a, turbo);
	assign nes_joy_b = map_pad(joy_b, turbo);

endmodule

// File: project.f
nes_glue_pkg.sv
pad_mapper.sv
joypad_serial.sv
reset_sequencer.sv
loader_write_sync.sv
backup_ram_ctrl.sv
nes_host_glue.sv
tb_nes_host_glue.sv

// File: reset_sequencer.sv
/* machine reset sequencing */

`timescale 1ns/1ns

module reset_sequencer
	import nes_glue_pkg::*;
#(
	parameter int download_hold = 255
) (
	input  logic clk,
	input  logic reset_nes,
	input  logic reset_button,
	input  logic arm_reset,
	input  logic downloading,
	input  logic loader_busy,
	input  logic loader_fail,
	output logic machine_reset
);

	localparam int cnt_bits = $clog2(download_hold + 1);

	logic                init_hold;
	logic [cnt_bits-1:0] hold_cnt;

	// held until the first download starts
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			init_hold <= 1'b1;
		end else if (downloading) begin
			init_hold <= 1'b0;
		end
	end

	// count only while the loader is idle
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			hold_cnt <= '0;
		end else if (downloading) begin
			hold_cnt <= cnt_bits'(download_hold);
		end else if (hold_cnt != '0 && !loader_busy) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign machine_reset = init_hold | reset_button | arm_reset | loader_fail
		| (hold_cnt != '0);

	// post-download hold is armed when the download ends
	a_hold_keeps_reset: assert property (@(posedge clk) disable iff (reset_nes)
		$fell(downloading) |-> machine_reset);

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert --timescale 1ns/1ns -f project.f \
	--top-module tb_nes_host_glue -o tb_sim &&
out=$(./obj_dir/tb_sim) &&
echo "$out" &&
echo "$out" | grep -qx "all tests passed" ||
{ echo "simulation did not pass"; exit 1; }

// File: tb_nes_host_glue.sv
/* nes host glue testbench */

`timescale 1ns/1ns

module tb_nes_host_glue;

	localparam int clk_period = 4;
	// reset, sequencing, pad reads, reset requests, loader, cpu, backup
	localparam int test_cycles = 4 + 60 + 20 * 22 + 40 + 8 * 20 + 20 + 6 * 60 + 120;
	localparam int watchdog_ns = 2 * test_cycles * clk_period;

	logic        clk;
	logic        reset_nes;
	logic [15:0] host_joy_a;
	logic [15:0] host_joy_b;
	logic        joy_swap;
	logic        joypad_strobe;
	logic [1:0]  joypad_clock;
	logic        reset_button;
	logic        arm_reset;
	logic        downloading;
	logic        loader_busy;
	logic        loader_fail;
	logic        loader_write;
	logic [21:0] loader_addr;
	logic [7:0]  loader_data;
	logic [1:0]  mem_phase = 2'd0;
	logic [21:0] cpu_addr;
	logic        cpu_read;
	logic        cpu_write;
	logic [7:0]  cpu_dout;
	logic        img_mounted;
	logic [31:0] img_size;
	logic        bk_save;
	logic        sd_ack;
	logic [8:0]  sd_buff_addr;
	logic        sd_buff_wr;
	logic        sd_buff_rd;
	logic        joypad1_data;
	logic        joypad2_data;
	logic        machine_reset;
	logic [21:0] mem_addr_b;
	logic        mem_we_b;
	logic        mem_oe_b;
	logic [7:0]  mem_din_b;
	logic [31:0] sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic [21:0] sram_addr;
	logic        sram_req;
	logic        sram_we;
	logic        save_enabled;

	logic [3:0]  turbo_ref;
	int          errors = 0;
	int          checks = 0;

	nes_host_glue #(
		.turbo_bits   (4),
		.download_hold(16)
	) i_nes_host_glue (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// free 2-bit core phase
	always @(negedge clk) begin
		mem_phase <= mem_phase + 2'd1;
	end

	// turbo reference, counts from zero once reset drops
	always @(posedge clk) begin
		if (reset_nes) begin
			turbo_ref <= '0;
		end else begin
			turbo_ref <= turbo_ref + 4'd1;
		end
	end

	a_oe_masked_loading: assert property (@(posedge clk) disable iff (reset_nes)
		(downloading || loader_busy) |-> !mem_oe_b)
		else begin
			errors++;
			$display("port B passed a CPU read while the loader owned it");
		end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	// nes serial order, bit 0 first: A B select start up down left right
	function automatic logic [7:0] nes_order(input logic [15:0] joy, input logic gate);
		int         src [8] = '{4, 5, 6, 7, 3, 2, 1, 0};
		logic [7:0] word;
		for (int k = 0; k < 8; k++) begin
			word[k] = joy[src[k]];
		end
		word[0] = word[0] | (joy[8] & gate);
		word[1] = word[1] | (joy[9] & gate);
		return word;
	endfunction

	// strobe, then nine reads with eight falling joypad clocks between
	task automatic read_pads();
		logic [8:0] bits1;
		logic [8:0] bits2;
		logic       gate;
		gate = turbo_ref[3];
		bits1 = {1'b0, nes_order(joy_swap ? host_joy_b : host_joy_a, gate)};
		bits2 = {1'b0, nes_order(joy_swap ? host_joy_a : host_joy_b, gate)};
		joypad_strobe = 1'b1;
		@(negedge clk);
		joypad_strobe = 1'b0;
		for (int k = 0; k < 9; k++) begin
			check_value("joypad1_data", 32'(bits1[k]), 32'(joypad1_data));
			check_value("joypad2_data", 32'(bits2[k]), 32'(joypad2_data));
			if (k < 8) begin
				joypad_clock = 2'b11;
				@(negedge clk);
				joypad_clock = 2'b00;
				@(negedge clk);
			end
		end
	endtask

	task automatic loader_write_check();
		logic [21:0] addr;
		logic [7:0]  data;
		logic [1:0]  edge_phase;
		int          wait_edges;
		addr = 22'($urandom());
		data = 8'($urandom());
		// phase seen by the next rising edge
		edge_phase = mem_phase + 2'd1;
		wait_edges = int'(2'd3 - edge_phase);
		loader_write = 1'b1;
		loader_addr = addr;
		loader_data = data;
		cpu_read = 1'b1;
		for (int k = 0; k <= wait_edges + 4; k++) begin
			@(negedge clk);
			loader_write = 1'b0;
			check_value("mem_we_b", 32'(k >= wait_edges && k < wait_edges + 4), 32'(mem_we_b));
			check_value("mem_addr_b", 32'(addr), 32'(mem_addr_b));
			check_value("mem_din_b", 32'(data), 32'(mem_din_b));
			check_value("mem_oe_b", 32'd0, 32'(mem_oe_b));
		end
	endtask

	task automatic expect_no_request(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_value("sd_rd", 32'd0, 32'(sd_rd));
			check_value("sd_wr", 32'd0, 32'(sd_wr));
		end
	endtask

	// host side of the sd block handshake, one buffer byte per block
	task automatic serve_blocks(input logic is_load, input int blocks);
		int         waited;
		logic [8:0] baddr;
		logic       req_before;
		for (int b = 0; b < blocks; b++) begin
			waited = 0;
			while (!(sd_rd || sd_wr) && waited < 40) begin
				@(negedge clk);
				waited++;
			end
			if (waited == 40) begin
				errors++;
				$display("no SD request appeared for block %0d", b);
				return;
			end
			check_value("sd_rd", 32'(is_load), 32'(sd_rd));
			check_value("sd_wr", 32'(!is_load), 32'(sd_wr));
			check_value("sd_lba", 32'(b), sd_lba);
			sd_ack = 1'b1;
			@(negedge clk);
			baddr = 9'($urandom());
			req_before = sram_req;
			sd_buff_addr = baddr;
			sd_buff_wr = is_load;
			sd_buff_rd = !is_load;
			@(negedge clk);
			sd_buff_wr = 1'b0;
			sd_buff_rd = 1'b0;
			check_value("sram_req", 32'(!req_before), 32'(sram_req));
			check_value("sram_we", 32'(is_load), 32'(sram_we));
			check_value("sram_addr", 32'({4'd15, 9'(b), baddr}), 32'(sram_addr));
			check_value("sd_rd", 32'd0, 32'(sd_rd | sd_wr));
			sd_ack = 1'b0;
			@(negedge clk);
		end
		expect_no_request(20);
	endtask

	initial begin
		#(watchdog_ns);
		$display("watchdog expired before the tests finished");
		$display("tests failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h2347));
		reset_nes = 1'b1;
		host_joy_a = '0;
		host_joy_b = '0;
		joy_swap = 1'b0;
		joypad_strobe = 1'b0;
		joypad_clock = 2'b00;
		reset_button = 1'b0;
		arm_reset = 1'b0;
		downloading = 1'b0;
		loader_busy = 1'b0;
		loader_fail = 1'b0;
		loader_write = 1'b0;
		loader_addr = '0;
		loader_data = '0;
		cpu_addr = '0;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		cpu_dout = '0;
		img_mounted = 1'b0;
		img_size = '0;
		bk_save = 1'b0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr = 1'b0;
		sd_buff_rd = 1'b0;
		repeat (4) @(negedge clk);
		reset_nes = 1'b0;

		// held in reset until a download has come and gone
		repeat (10) begin
			@(negedge clk);
			check_value("machine_reset", 32'd1, 32'(machine_reset));
		end
		downloading = 1'b1;
		@(negedge clk);
		downloading = 1'b0;
		for (int k = 0; k < 16; k++) begin
			check_value("machine_reset", 32'd1, 32'(machine_reset));
			@(negedge clk);
		end
		check_value("machine_reset", 32'd0, 32'(machine_reset));

		for (int r = 0; r < 8; r++) begin
			joy_swap = (r >= 4);
			host_joy_a = 16'($urandom()) & 16'h00ff;
			host_joy_b = 16'($urandom()) & 16'h00ff;
			read_pads();
		end

		// X and Y held, A and B released
		for (int r = 0; r < 8; r++) begin
			joy_swap = r[0];
			host_joy_a = (16'($urandom()) & 16'h00cf) | 16'h0300;
			host_joy_b = (16'($urandom()) & 16'h00cf) | 16'h0300;
			repeat ($urandom_range(0, 7)) @(negedge clk);
			read_pads();
		end

		reset_button = 1'b1;
		#1 check_value("machine_reset", 32'd1, 32'(machine_reset));
		@(negedge clk);
		reset_button = 1'b0;
		#1 check_value("machine_reset", 32'd0, 32'(machine_reset));
		@(negedge clk);
		loader_fail = 1'b1;
		#1 check_value("machine_reset", 32'd1, 32'(machine_reset));
		@(negedge clk);
		loader_fail = 1'b0;
		#1 check_value("machine_reset", 32'd0, 32'(machine_reset));

		@(negedge clk);
		downloading = 1'b1;
		for (int r = 0; r < 8; r++) begin
			repeat ($urandom_range(0, 3)) @(negedge clk);
			loader_write_check();
		end
		downloading = 1'b0;
		for (int r = 0; r < 8; r++) begin
			cpu_read = 1'($urandom());
			cpu_write = 1'($urandom());
			cpu_addr = 22'($urandom());
			cpu_dout = 8'($urandom());
			#1 check_value("mem_oe_b", 32'(cpu_read), 32'(mem_oe_b));
			check_value("mem_addr_b", 32'(cpu_addr), 32'(mem_addr_b));
			check_value("mem_din_b", 32'(cpu_dout), 32'(mem_din_b));
			check_value("mem_we_b", 32'(cpu_write), 32'(mem_we_b));
			@(negedge clk);
		end
		cpu_write = 1'b0;

		// size field 20:9 of 2 gives three blocks
		img_size = 32'd1535;
		img_mounted = 1'b1;
		@(negedge clk);
		serve_blocks(1'b1, 3);
		img_mounted = 1'b0;
		check_value("save_enabled", 32'd1, 32'(save_enabled));
		bk_save = 1'b1;
		@(negedge clk);
		bk_save = 1'b0;
		serve_blocks(1'b0, 3);

		img_size = '0;
		img_mounted = 1'b1;
		repeat (2) @(negedge clk);
		img_mounted = 1'b0;
		check_value("save_enabled", 32'd0, 32'(save_enabled));
		bk_save = 1'b1;
		@(negedge clk);
		bk_save = 1'b0;
		expect_no_request(20);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
